//--- lcdController.f
+incdir+rtl
+incdir+tests
rtl/lcdCmdPkg.sv
rtl/lcdPixelPkg.sv
rtl/lcdRequestRegs.sv
rtl/lcdSequencer.sv
rtl/lcdBusWriter.sv
rtl/lcdController.sv
tests/lcdControllerTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --timescale 1ns/10ps --top-module lcdControllerTb \
  -f lcdController.f -o simv > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- tests/lcdRefModel.svh
`ifndef LCD_REF_MODEL_SVH
`define LCD_REF_MODEL_SVH

// opcode numbering: 0 init, 1 display off, 2 display on, 3 draw pixel
// color numbering: 0 red, 1 green, 2 blue, 3 black, 4 white

// rgb565 word of each color select
function automatic logic [15:0] colorWord(input int color);
  case (color)
    0: return 16'hF800;
    1: return 16'h07E0;
    2: return 16'h001F;
    4: return 16'hFFFF;
    default: return 16'h0000;
  endcase
endfunction

// bus writes per request
function automatic int byteCount(input int op);
  case (op)
    0: return 7;
    1, 2: return 2;
    default: return 13;
  endcase
endfunction

// {dcx, data} of write number idx, dcx low for commands
function automatic logic [8:0] expectedByte(input int op, input int color,
    input logic [15:0] x, input logic [15:0] y, input int idx);
  logic [15:0] word;
  word = colorWord(color);
  case (op)
    0: begin
      case (idx)
        0: return {1'b0, 8'h01};
        1: return {1'b0, 8'h11};
        2: return {1'b0, 8'h3A};
        3: return {1'b1, 8'h55};
        4: return {1'b0, 8'h36};
        5: return {1'b1, 8'hB8};
        default: return {1'b0, 8'h29};
      endcase
    end
    1: return (idx == 0) ? {1'b0, 8'h28} : {1'b0, 8'h10};
    2: return (idx == 0) ? {1'b0, 8'h11} : {1'b0, 8'h29};
    default: begin
      // one pixel window, each coordinate sent as start and end
      case (idx)
        0: return {1'b0, 8'h2A};
        1, 3: return {1'b1, x[15:8]};
        2, 4: return {1'b1, x[7:0]};
        5: return {1'b0, 8'h2B};
        6, 8: return {1'b1, y[15:8]};
        7, 9: return {1'b1, y[7:0]};
        10: return {1'b0, 8'h2C};
        11: return {1'b1, word[15:8]};
        default: return {1'b1, word[7:0]};
      endcase
    end
  endcase
endfunction

// least number of cycles between the previous write and write idx
function automatic int gapBefore(input int op, input int idx);
  if (op == 0 && idx == 1) return `LCD_RESET_WAIT;
  if (op == 0 && idx == 2) return `LCD_SLEEP_WAIT;
  if (op == 1 && idx == 1) return `LCD_OFF_WAIT;
  if (op == 2 && idx == 1) return `LCD_SLEEP_WAIT;
  return 0;
endfunction

// display off ends with a wait before csx goes back up
function automatic int gapAfter(input int op);
  return (op == 1) ? `LCD_OFF_WAIT : 0;
endfunction

`endif

//--- tests/lcdControllerTb.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcdControllerTb;

  localparam int numRequests = 40;
  // init is the longest request
  localparam int longestOp = 11 * 2 + `LCD_RESET_WAIT + `LCD_SLEEP_WAIT + 32;
  localparam int timeoutCycles = 2 * numRequests * longestOp;

  logic                     clk;
  logic                     rst;
  logic                     start;
  lcdCmdPkg::opcode_e       op;
  lcdPixelPkg::color_e      color;
  logic [`LCD_COORD_W-1:0]  x;
  logic [`LCD_COORD_W-1:0]  y;
  logic                     ack;
  logic                     csx;
  logic                     dcx;
  logic                     wrx;
  logic [`LCD_BUS_W-1:0]    data;

  logic [31:0] lcgState = 32'h6f02;
  int          cycleNum = 0;
  int          acceptedCount = 0;
  int          ackCount = 0;
  int          framesOpened = 0;
  int          lastRise = 0;
  int          csxRise = 0;
  logic        wrxPrev = 1'b1;
  logic        csxPrev = 1'b1;
  logic [8:0]  expBytes[$];
  int          expGaps[$];
  int          expTrail[$];

  `include "lcdRefModel.svh"

  lcdController u_dut (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .op    (op),
    .color (color),
    .x     (x),
    .y     (y),
    .ack   (ack),
    .csx   (csx),
    .dcx   (dcx),
    .wrx   (wrx),
    .data  (data)
  );

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string msg);
    abortRun($sformatf("MISMATCH at %0t: %s", $time, msg));
  endtask

  function automatic logic [15:0] randWord();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];
  endfunction

  function automatic int randBelow(input int n);
    return int'(randWord()) % n;
  endfunction

  task automatic checkIdleBus(input string when);
    assert (csx && wrx && dcx && data == '0 && !ack)
      else reportMismatch($sformatf("bus not idle %s, csx=%0b wrx=%0b dcx=%0b data=%h ack=%0b",
        when, csx, wrx, dcx, data, ack));
  endtask

  // queues the model's writes, pulses start and waits for ack
  task automatic issueRequest(input int opSel);
    int          colorSel;
    int          gap;
    logic [15:0] xv;
    logic [15:0] yv;
    colorSel = randBelow(5);
    gap = randBelow(6);
    xv = randWord();
    yv = randWord();
    repeat (gap) @(negedge clk);
    for (int i = 0; i < byteCount(opSel); i++) begin
      expBytes.push_back(expectedByte(opSel, colorSel, xv, yv, i));
      expGaps.push_back(gapBefore(opSel, i));
    end
    expTrail.push_back(gapAfter(opSel));
    acceptedCount++;
    start = 1'b1;
    op = lcdCmdPkg::opcode_e'(2'(opSel));
    color = lcdPixelPkg::color_e'(3'(colorSel));
    x = xv;
    y = yv;
    @(negedge clk);
    start = 1'b0;
    // request is latched, so the inputs may wander
    x = randWord();
    y = randWord();
    color = lcdPixelPkg::color_e'(3'(randBelow(5)));
    if (randBelow(3) == 0) begin
      repeat (2) @(negedge clk);
      start = 1'b1;
      op = lcdCmdPkg::opcode_e'(2'(randBelow(4)));
      @(negedge clk);
      start = 1'b0;
    end
    while (!ack) @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleNum++;
    if (cycleNum > timeoutCycles)
      abortRun($sformatf("timeout, the run went past %0d cycles", timeoutCycles));
  end

  // bus monitor, outputs are settled at the falling edge
  always @(negedge clk) begin
    logic [8:0] exp;
    int         gap;
    if (!rst) begin
      if (wrx && !wrxPrev) begin
        assert (!csx) else abortRun("wrx rose while csx was high");
        assert (expBytes.size() > 0) else abortRun("bus write when no write was expected");
        exp = expBytes.pop_front();
        gap = expGaps.pop_front();
        assert ({dcx, data} == exp)
          else reportMismatch($sformatf("write dcx=%0b data=%h, expected dcx=%0b data=%h",
            dcx, data, exp[8], exp[7:0]));
        assert (cycleNum - lastRise >= gap)
          else reportMismatch($sformatf("write %0d cycles after previous, wait is %0d",
            cycleNum - lastRise, gap));
        lastRise = cycleNum;
      end
      if (!csx && csxPrev) begin
        assert (framesOpened < acceptedCount) else abortRun("csx fell with no request accepted");
        framesOpened++;
      end
      if (csx && !csxPrev) begin
        assert (expBytes.size() == 0 && expTrail.size() > 0)
          else abortRun("csx rose before all writes of the request were seen");
        gap = expTrail.pop_front();
        assert (cycleNum - lastRise >= gap)
          else reportMismatch($sformatf("csx rose %0d cycles after last write, wait is %0d",
            cycleNum - lastRise, gap));
        csxRise = cycleNum;
      end
      if (ack) begin
        ackCount++;
        assert (ackCount <= acceptedCount) else abortRun("ack with no request left to finish");
        assert (csx && csxRise < cycleNum && ackCount == framesOpened)
          else abortRun("ack came before csx returned high for its frame");
        // dcx back high and data cleared once the frame is closed
        assert (dcx && data == '0)
          else reportMismatch($sformatf("bus not idle at ack, dcx=%0b data=%h", dcx, data));
      end
    end
    wrxPrev = wrx;
    csxPrev = csx;
  end

  initial begin
    int opSel;
    rst = 1'b1;
    start = 1'b0;
    op = lcdCmdPkg::opInit;
    color = lcdPixelPkg::colorRed;
    x = '0;
    y = '0;
    repeat (10) begin
      @(negedge clk);
      checkIdleBus("during reset");
    end
    rst = 1'b0;
    @(negedge clk);
    checkIdleBus("after reset");
    for (int i = 0; i < numRequests; i++) begin
      // first eight requests give every opcode twice
      opSel = (i < 8) ? i % 4 : randBelow(4);
      issueRequest(opSel);
    end
    repeat (8) @(negedge clk);
    if (ackCount == acceptedCount && framesOpened == acceptedCount && expBytes.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abortRun("request, frame and ack counts differ at the end of the run");
    end
  end

endmodule

//--- rtl/lcdController.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcdController (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  lcdCmdPkg::opcode_e       op,
  input  lcdPixelPkg::color_e      color,
  input  logic [`LCD_COORD_W-1:0]  x,
  input  logic [`LCD_COORD_W-1:0]  y,
  output logic                     ack,
  output logic                     csx,
  output logic                     dcx,
  output logic                     wrx,
  output logic [`LCD_BUS_W-1:0]    data
);

  lcdCmdPkg::opcode_e         reqOp;
  lcdPixelPkg::color_e        reqColor;
  logic [`LCD_COORD_W-1:0]    reqX;
  logic [`LCD_COORD_W-1:0]    reqY;
  logic                       launch;
  logic                       seqDone;
  logic                       frameOpen;
  logic                       byteValid;
  logic                       byteIsData;
  logic [`LCD_BUS_W-1:0]      byteValue;
  logic                       byteDone;

  lcdRequestRegs u_requestRegs (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .op       (op),
    .color    (color),
    .x        (x),
    .y        (y),
    .seqDone  (seqDone),
    .reqOp    (reqOp),
    .reqColor (reqColor),
    .reqX     (reqX),
    .reqY     (reqY),
    .launch   (launch),
    .ack      (ack)
  );

  lcdSequencer u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .launch     (launch),
    .reqOp      (reqOp),
    .reqColor   (reqColor),
    .reqX       (reqX),
    .reqY       (reqY),
    .byteDone   (byteDone),
    .frameOpen  (frameOpen),
    .byteValid  (byteValid),
    .byteIsData (byteIsData),
    .byteValue  (byteValue),
    .seqDone    (seqDone)
  );

  lcdBusWriter u_busWriter (
    .clk        (clk),
    .rst        (rst),
    .frameOpen  (frameOpen),
    .byteValid  (byteValid),
    .byteIsData (byteIsData),
    .byteValue  (byteValue),
    .csx        (csx),
    .dcx        (dcx),
    .wrx        (wrx),
    .data       (data),
    .byteDone   (byteDone)
  );

endmodule

//--- rtl/lcdBusWriter.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcdBusWriter (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   frameOpen,
  input  logic                   byteValid,
  input  logic                   byteIsData,
  input  logic [`LCD_BUS_W-1:0]  byteValue,
  output logic                   csx,
  output logic                   dcx,
  output logic                   wrx,
  output logic [`LCD_BUS_W-1:0]  data,
  output logic                   byteDone
);

  // wrx is also the write phase: low phase then high phase
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      csx      <= 1'b1;
      dcx      <= 1'b1;
      wrx      <= 1'b1;
      data     <= '0;
      byteDone <= 1'b0;
    end else begin
      csx      <= !frameOpen;
      byteDone <= 1'b0;
      if (byteValid) begin
        // command bytes go out with dcx low
        wrx  <= 1'b0;
        dcx  <= byteIsData;
        data <= byteValue;
      end else if (!wrx) begin
        // panel latches dcx and data on this rising edge
        wrx      <= 1'b1;
        byteDone <= 1'b1;
      end else if (!frameOpen) begin
        dcx  <= 1'b1;
        data <= '0;
      end
    end
  end

  // strobe must sit inside a chip select frame
  wrxInsideFrame: assert property (@(posedge clk) disable iff (rst)
    !wrx |-> !csx)
    else $error("wrx low while csx high");

endmodule

//--- rtl/lcdSequencer.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcdSequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     launch,
  input  lcdCmdPkg::opcode_e       reqOp,
  input  lcdPixelPkg::color_e      reqColor,
  input  logic [`LCD_COORD_W-1:0]  reqX,
  input  logic [`LCD_COORD_W-1:0]  reqY,
  input  logic                     byteDone,
  output logic                     frameOpen,
  output logic                     byteValid,
  output logic                     byteIsData,
  output logic [`LCD_BUS_W-1:0]    byteValue,
  output logic                     seqDone
);

  localparam logic [`LCD_BUS_W+1:0] endEntry = {lcdCmdPkg::stepEnd, `LCD_BUS_W'(0)};

  logic                       active;
  logic                       pending;
  logic                       byteInFlight;
  logic [3:0]                 stepIdx;
  logic [`LCD_WAIT_W-1:0]     waitCnt;
  logic [`LCD_WAIT_W-1:0]     waitLen;
  logic [`LCD_BUS_W+1:0]      entry;
  lcdCmdPkg::stepKind_e       stepKind;
  logic [`LCD_BUS_W-1:0]      stepByte;
  logic [`LCD_BUS_W-1:0]      xHi;
  logic [`LCD_BUS_W-1:0]      xLo;
  logic [`LCD_BUS_W-1:0]      yHi;
  logic [`LCD_BUS_W-1:0]      yLo;
  lcdPixelPkg::pixel_u        pixel;

  assign xHi = reqX[`LCD_COORD_W-1 -: `LCD_BUS_W];
  assign xLo = reqX[`LCD_BUS_W-1:0];
  assign yHi = reqY[`LCD_COORD_W-1 -: `LCD_BUS_W];
  assign yLo = reqY[`LCD_BUS_W-1:0];

  // color is set up field by field, sent byte by byte
  always_comb begin
    pixel = '0;
    case (reqColor)
      lcdPixelPkg::colorRed:   pixel.rgb.red = '1;
      lcdPixelPkg::colorGreen: pixel.rgb.green = '1;
      lcdPixelPkg::colorBlue:  pixel.rgb.blue = '1;
      lcdPixelPkg::colorWhite: begin
        pixel.rgb.red   = '1;
        pixel.rgb.green = '1;
        pixel.rgb.blue  = '1;
      end
      default: pixel = '0;
    endcase
  end

  // step table, wait entries carry their length in the byte field
  always_comb begin
    entry = endEntry;
    case (reqOp)
      lcdCmdPkg::opInit: begin
        case (stepIdx)
          4'd0: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdSwReset};
          4'd1: entry = {lcdCmdPkg::stepWait, `LCD_BUS_W'(`LCD_RESET_WAIT)};
          4'd2: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdSleepOut};
          4'd3: entry = {lcdCmdPkg::stepWait, `LCD_BUS_W'(`LCD_SLEEP_WAIT)};
          4'd4: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdPixelFormat};
          4'd5: entry = {lcdCmdPkg::stepData, lcdCmdPkg::paramPixelFormat};
          4'd6: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdMemAccess};
          4'd7: entry = {lcdCmdPkg::stepData, lcdCmdPkg::paramMemAccess};
          4'd8: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdDisplayOn};
          default: entry = endEntry;
        endcase
      end
      lcdCmdPkg::opDisplayOff: begin
        case (stepIdx)
          4'd0: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdDisplayOff};
          4'd1: entry = {lcdCmdPkg::stepWait, `LCD_BUS_W'(`LCD_OFF_WAIT)};
          4'd2: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdSleepIn};
          4'd3: entry = {lcdCmdPkg::stepWait, `LCD_BUS_W'(`LCD_OFF_WAIT)};
          default: entry = endEntry;
        endcase
      end
      lcdCmdPkg::opDisplayOn: begin
        case (stepIdx)
          4'd0: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdSleepOut};
          4'd1: entry = {lcdCmdPkg::stepWait, `LCD_BUS_W'(`LCD_SLEEP_WAIT)};
          4'd2: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdDisplayOn};
          default: entry = endEntry;
        endcase
      end
      default: begin
        // one pixel window, start and end equal
        case (stepIdx)
          4'd0:  entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdColumnAddr};
          4'd1:  entry = {lcdCmdPkg::stepData, xHi};
          4'd2:  entry = {lcdCmdPkg::stepData, xLo};
          4'd3:  entry = {lcdCmdPkg::stepData, xHi};
          4'd4:  entry = {lcdCmdPkg::stepData, xLo};
          4'd5:  entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdRowAddr};
          4'd6:  entry = {lcdCmdPkg::stepData, yHi};
          4'd7:  entry = {lcdCmdPkg::stepData, yLo};
          4'd8:  entry = {lcdCmdPkg::stepData, yHi};
          4'd9:  entry = {lcdCmdPkg::stepData, yLo};
          4'd10: entry = {lcdCmdPkg::stepCmd, lcdCmdPkg::cmdMemWrite};
          4'd11: entry = {lcdCmdPkg::stepData, pixel.bytes.hi};
          4'd12: entry = {lcdCmdPkg::stepData, pixel.bytes.lo};
          default: entry = endEntry;
        endcase
      end
    endcase
  end

  assign stepKind = lcdCmdPkg::stepKind_e'(entry[`LCD_BUS_W +: 2]);
  assign stepByte = entry[`LCD_BUS_W-1:0];
  assign waitLen  = `LCD_WAIT_W'(stepByte);

  // drops on the end step so csx is back up before ack
  assign frameOpen = launch || (active && stepKind != lcdCmdPkg::stepEnd);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active    <= 1'b0;
      pending   <= 1'b0;
      stepIdx   <= '0;
      waitCnt   <= '0;
      byteValid <= 1'b0;
      seqDone   <= 1'b0;
    end else begin
      byteValid <= 1'b0;
      seqDone   <= 1'b0;
      if (launch) begin
        active  <= 1'b1;
        pending <= 1'b0;
        stepIdx <= '0;
        waitCnt <= '0;
      end else if (active) begin
        case (stepKind)
          lcdCmdPkg::stepCmd, lcdCmdPkg::stepData: begin
            if (!pending) begin
              byteValid <= 1'b1;
              pending   <= 1'b1;
            end else if (byteDone) begin
              pending <= 1'b0;
              stepIdx <= stepIdx + 4'd1;
            end
          end
          lcdCmdPkg::stepWait: begin
            if (waitCnt == waitLen - `LCD_WAIT_W'(1)) begin
              waitCnt <= '0;
              stepIdx <= stepIdx + 4'd1;
            end else begin
              waitCnt <= waitCnt + `LCD_WAIT_W'(1);
            end
          end
          default: begin
            active  <= 1'b0;
            stepIdx <= '0;
            seqDone <= 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && !pending) begin
      byteIsData <= (stepKind == lcdCmdPkg::stepData);
      byteValue  <= stepByte;
    end
  end

  // a byte handed to the writer stays open until the writer reports it done
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      byteInFlight <= 1'b0;
    end else if (byteValid) begin
      byteInFlight <= 1'b1;
    end else if (byteDone) begin
      byteInFlight <= 1'b0;
    end
  end

  // one byte in flight at a time, the writer never sees an overlap
  oneByteOutstanding: assert property (@(posedge clk) disable iff (rst)
    byteValid |-> !byteInFlight)
    else $error("byteValid issued before byteDone");

endmodule

//--- rtl/lcdRequestRegs.sv
`timescale 1ns/10ps
`include "lcd_settings.svh"

module lcdRequestRegs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  lcdCmdPkg::opcode_e       op,
  input  lcdPixelPkg::color_e      color,
  input  logic [`LCD_COORD_W-1:0]  x,
  input  logic [`LCD_COORD_W-1:0]  y,
  input  logic                     seqDone,
  output lcdCmdPkg::opcode_e       reqOp,
  output lcdPixelPkg::color_e      reqColor,
  output logic [`LCD_COORD_W-1:0]  reqX,
  output logic [`LCD_COORD_W-1:0]  reqY,
  output logic                     launch,
  output logic                     ack
);

  logic busy;
  logic accept;

  // starts during a running operation are dropped
  assign accept = start && !busy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy   <= 1'b0;
      launch <= 1'b0;
      ack    <= 1'b0;
    end else begin
      launch <= accept;
      ack    <= seqDone;
      if (accept) begin
        busy <= 1'b1;
      end else if (seqDone) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqOp    <= op;
      reqColor <= color;
      reqX     <= x;
      reqY     <= y;
    end
  end

  // a new launch cannot overlap the ack of the previous request
  launchAckExclusive: assert property (@(posedge clk) disable iff (rst)
    !(launch && ack))
    else $error("launch and ack high together");

  // the sequencer only finishes work that was handed to it
  doneOnlyWhenBusy: assert property (@(posedge clk) disable iff (rst)
    seqDone |-> busy)
    else $error("seqDone without a request in flight");

endmodule

//--- rtl/lcdPixelPkg.sv
`include "lcd_settings.svh"

package lcdPixelPkg;

  // fixed colors a pixel request can pick
  typedef enum logic [2:0] {
    colorRed,
    colorGreen,
    colorBlue,
    colorBlack,
    colorWhite
  } color_e;

  // rgb565 field layout, red in the top bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_s;

  // the same word as it goes out on the bus, high byte first
  typedef struct packed {
    logic [`LCD_BUS_W-1:0] hi;
    logic [`LCD_BUS_W-1:0] lo;
  } pixelBytes_s;

  typedef union packed {
    rgb565_s     rgb;
    pixelBytes_s bytes;
  } pixel_u;

endpackage

//--- rtl/lcdCmdPkg.sv
`include "lcd_settings.svh"

package lcdCmdPkg;

  // host request opcodes
  typedef enum logic [`LCD_OP_W-1:0] {
    opInit,
    opDisplayOff,
    opDisplayOn,
    opDrawPixel
  } opcode_e;

  // kinds of entries in the sequence table
  typedef enum logic [1:0] {
    stepCmd,
    stepData,
    stepWait,
    stepEnd
  } stepKind_e;

  // panel command codes
  parameter logic [`LCD_BUS_W-1:0] cmdSwReset     = 8'h01;
  parameter logic [`LCD_BUS_W-1:0] cmdSleepIn     = 8'h10;
  parameter logic [`LCD_BUS_W-1:0] cmdSleepOut    = 8'h11;
  parameter logic [`LCD_BUS_W-1:0] cmdDisplayOff  = 8'h28;
  parameter logic [`LCD_BUS_W-1:0] cmdDisplayOn   = 8'h29;
  parameter logic [`LCD_BUS_W-1:0] cmdColumnAddr  = 8'h2A;
  parameter logic [`LCD_BUS_W-1:0] cmdRowAddr     = 8'h2B;
  parameter logic [`LCD_BUS_W-1:0] cmdMemWrite    = 8'h2C;
  parameter logic [`LCD_BUS_W-1:0] cmdMemAccess   = 8'h36;
  parameter logic [`LCD_BUS_W-1:0] cmdPixelFormat = 8'h3A;

  // 16 bits per pixel
  parameter logic [`LCD_BUS_W-1:0] paramPixelFormat = 8'h55;
  // row/column exchange and mirror, BGR order
  parameter logic [`LCD_BUS_W-1:0] paramMemAccess   = 8'hB8;

endpackage

//--- rtl/lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// panel data bus
`define LCD_BUS_W 8

// pixel window coordinates
`define LCD_COORD_W 16

// request opcode
`define LCD_OP_W 2

// wait lengths in clock cycles, sized for simulation
// after software reset
`define LCD_RESET_WAIT 40
// after sleep out
`define LCD_SLEEP_WAIT 60
// after display off or sleep in
`define LCD_OFF_WAIT 30

// wait counter, must hold the longest wait
`define LCD_WAIT_W 8

`endif
